// ==== include/loader_defines.svh ====
////////////////////////////////////////
// Loader constants
// Host index codes, address limits and pointer cells
////////////////////////////////////////

`ifndef LOADER_DEFINES_SVH
`define LOADER_DEFINES_SVH

// Host file index codes
`define LD_IDX_PRG 8'h01
`define LD_IDX_ROM 8'h06
`define LD_IDX_CRT 8'h41
`define LD_IDX_CT  8'h81

// Exclusive upper bounds for kept data
`define LD_PRG_LIMIT  16'hA000
`define LD_CART_LIMIT 16'hC000

// Kernal image window in host offsets, moved up in memory
`define LD_ROM_LO    25'h0004000
`define LD_ROM_HI    25'h0008000
`define LD_ROM_SHIFT 16'h8000

// BASIC pointer cells patched after a program load
`define LD_PTR_COUNT 8
`define LD_PTR_BASE  16'h002D
`define LD_PTR_EAL   16'h00AE

// Tracked 8 KB cartridge blocks
`define LD_CART_BLOCKS 5

`endif

// ==== logic/media_pkg.sv ====
////////////////////////////////////////
// Media types
// File kinds and machine address spaces
////////////////////////////////////////

package media_pkg;

	// Kind of file being downloaded
	typedef enum logic [2:0] {
		NONE,
		PRG,
		ROM,
		CRT,
		CT
	} file_kind_e;

	// Machine memory address
	typedef logic [15:0] mem_addr_t;

	// Byte offset within the host stream
	typedef logic [24:0] host_addr_t;

	// Touched cartridge blocks, bits for blocks 0 1 2 3 and 5
	typedef logic [4:0] cart_blk_t;

	// Expansion RAM enables in the same bit order
	typedef logic [4:0] ram_ext_t;

endpackage

// ==== logic/bus_pkg.sv ====
////////////////////////////////////////
// Bus types
////////////////////////////////////////

package bus_pkg;

	// Data byte on the host stream and memory bus
	typedef logic [7:0] byte_t;

	// Byte select of the 8 bit Wishbone port
	typedef logic [0:0] wb_sel_t;

endpackage

// ==== logic/load_stream_decoder.sv ====
////////////////////////////////////////
// Load stream decoder
// Turns host download bytes into memory writes
////////////////////////////////////////

`include "loader_defines.svh"

module load_stream_decoder (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ioctl_download_i,
	input  bus_pkg::byte_t       ioctl_index_i,
	input  logic                 ioctl_wr_i,
	input  media_pkg::host_addr_t ioctl_addr_i,
	input  bus_pkg::byte_t       ioctl_dout_i,
	input  bus_pkg::byte_t       ioctl_ext_i,
	input  logic                 dec_done_i,
	output logic                 dec_req_o,
	output media_pkg::mem_addr_t dec_adr_o,
	output bus_pkg::byte_t       dec_dat_o,
	output logic                 cart_wr_o,
	output logic                 prg_end_o,
	output media_pkg::mem_addr_t end_adr_o
);

	function automatic media_pkg::file_kind_e decode_kind(input bus_pkg::byte_t idx);
		case (idx)
			`LD_IDX_PRG: return media_pkg::PRG;
			`LD_IDX_ROM: return media_pkg::ROM;
			`LD_IDX_CRT: return media_pkg::CRT;
			`LD_IDX_CT:  return media_pkg::CT;
			default:     return media_pkg::NONE;
		endcase
	endfunction

	// Raw cartridge base from the last extension character
	function automatic media_pkg::mem_addr_t ct_base(input bus_pkg::byte_t ext,
			input media_pkg::mem_addr_t cur);
		if (ext >= "2" && ext <= "9")
			return {ext[3:0], 12'h000};
		if (ext >= "A" && ext <= "B")
			return {ext[3:0] + 4'd9, 12'h000};
		return cur;
	endfunction

	logic                  dl_prev;
	logic                  dl_start;
	logic                  hdr_byte;
	logic                  take;
	media_pkg::file_kind_e kind_q;
	media_pkg::file_kind_e kind_cur;
	media_pkg::mem_addr_t  addr_q;
	media_pkg::mem_addr_t  addr_cur;
	media_pkg::mem_addr_t  wr_adr;

	always_comb begin
		dl_start = ioctl_download_i && !dl_prev;
		kind_cur = dl_start ? decode_kind(ioctl_index_i) : kind_q;
		addr_cur = addr_q;
		if (dl_start && kind_cur == media_pkg::CT)
			addr_cur = ct_base(ioctl_ext_i, addr_q);
		// PRG and CRT files open with a little-endian load address
		hdr_byte = (kind_cur == media_pkg::PRG || kind_cur == media_pkg::CRT) &&
			(ioctl_addr_i < 25'd2);
		take = 1'b0;
		wr_adr = addr_cur;
		if (ioctl_download_i && ioctl_wr_i && !hdr_byte) begin
			case (kind_cur)
				media_pkg::PRG: take = addr_cur < `LD_PRG_LIMIT;
				media_pkg::CRT, media_pkg::CT: take = addr_cur < `LD_CART_LIMIT;
				media_pkg::ROM: begin
					take = ioctl_addr_i >= `LD_ROM_LO && ioctl_addr_i < `LD_ROM_HI;
					wr_adr = ioctl_addr_i[15:0] + `LD_ROM_SHIFT;
				end
				default: take = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_prev <= 1'b0;
			kind_q <= media_pkg::NONE;
			addr_q <= '0;
			dec_req_o <= 1'b0;
			cart_wr_o <= 1'b0;
			prg_end_o <= 1'b0;
		end else begin
			dl_prev <= ioctl_download_i;
			cart_wr_o <= 1'b0;
			prg_end_o <= 1'b0;
			if (dl_start)
				kind_q <= kind_cur;
			addr_q <= addr_cur;
			if (ioctl_download_i && ioctl_wr_i && hdr_byte) begin
				if (ioctl_addr_i[0])
					addr_q[15:8] <= ioctl_dout_i;
				else
					addr_q[7:0] <= ioctl_dout_i;
			end
			if (take && kind_cur != media_pkg::ROM)
				addr_q <= addr_cur + 16'd1;
			if (take)
				cart_wr_o <= kind_cur == media_pkg::CRT || kind_cur == media_pkg::CT;
			if (dec_done_i)
				dec_req_o <= 1'b0;
			if (take)
				dec_req_o <= 1'b1;
			// End of a program download triggers the pointer patch
			if (dl_prev && !ioctl_download_i && kind_q == media_pkg::PRG)
				prg_end_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			dec_adr_o <= wr_adr;
			dec_dat_o <= ioctl_dout_i;
		end
	end

	// Address just past the last kept byte
	assign end_adr_o = addr_q;

	// Host must be held off by the wait signal while a write is pending
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (reset)
		take |-> !dec_req_o);

endmodule

// ==== logic/basic_ptr_patcher.sv ====
////////////////////////////////////////
// BASIC pointer patcher
// Writes the program end address into the pointer cells
////////////////////////////////////////

`include "loader_defines.svh"

module basic_ptr_patcher (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 prg_end_i,
	input  media_pkg::mem_addr_t end_adr_i,
	input  logic                 pat_done_i,
	output logic                 pat_req_o,
	output media_pkg::mem_addr_t pat_adr_o,
	output bus_pkg::byte_t       pat_dat_o
);

	typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_e;

	state_e               state_q;
	logic [2:0]           step_q;
	media_pkg::mem_addr_t end_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q <= IDLE;
			step_q <= '0;
		end else begin
			case (state_q)
				IDLE: if (prg_end_i) state_q <= ISSUE;
				// One gap cycle so the bus master sees a fresh request
				ISSUE: state_q <= WAIT;
				WAIT: if (pat_done_i) begin
					if (step_q == 3'(`LD_PTR_COUNT - 1)) begin
						step_q <= '0;
						state_q <= IDLE;
					end else begin
						step_q <= step_q + 3'd1;
						state_q <= ISSUE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state_q == IDLE && prg_end_i)
			end_q <= end_adr_i;
	end

	// Cells 2D to 32 first, then AE and AF
	assign pat_adr_o = (step_q < 3'd6) ? `LD_PTR_BASE + media_pkg::mem_addr_t'(step_q) :
		`LD_PTR_EAL + media_pkg::mem_addr_t'(step_q - 3'd6);
	// Low byte on the first of each pair
	assign pat_dat_o = step_q[0] ? end_q[15:8] : end_q[7:0];
	assign pat_req_o = state_q == WAIT;

endmodule

// ==== logic/memory_config.sv ====
////////////////////////////////////////
// Expansion RAM configuration
// Option bits merged with loaded cartridge blocks
////////////////////////////////////////

`include "loader_defines.svh"

module memory_config (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 cart_wr_i,
	input  media_pkg::mem_addr_t cart_adr_i,
	input  logic                 opt_ram1_i,
	input  logic [1:0]           opt_ram2_i,
	input  logic                 opt_ram3_i,
	input  logic                 opt_cart_wr_i,
	output media_pkg::ram_ext_t  ram_ext_o,
	output media_pkg::ram_ext_t  ram_ext_ro_o
);

	// Mask bit 4 stands for block 5, block 4 is never tracked
	function automatic logic [2:0] blk_id(input int i);
		return (i == 4) ? 3'd5 : 3'(i);
	endfunction

	media_pkg::cart_blk_t blk_q;
	logic [2:0]           ram2_mask;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			blk_q <= '0;
		end else if (cart_wr_i) begin
			for (int i = 0; i < `LD_CART_BLOCKS; i++) begin
				if (cart_adr_i[15:13] == blk_id(i))
					blk_q[i] <= 1'b1;
			end
		end
	end

	// RAM2 option grows from 2000 upward in 8 KB steps
	always_comb begin
		case (opt_ram2_i)
			2'd0: ram2_mask = 3'b000;
			2'd1: ram2_mask = 3'b001;
			2'd2: ram2_mask = 3'b011;
			default: ram2_mask = 3'b111;
		endcase
	end

	assign ram_ext_o = {opt_ram3_i, ram2_mask, opt_ram1_i} | blk_q;
	assign ram_ext_ro_o = opt_cart_wr_i ? '0 : blk_q;

endmodule

// ==== logic/wb_write_master.sv ====
////////////////////////////////////////
// Wishbone write master
// Arbitrates decoder and patcher writes onto the bus
////////////////////////////////////////

module wb_write_master (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 dec_req_i,
	input  media_pkg::mem_addr_t dec_adr_i,
	input  bus_pkg::byte_t       dec_dat_i,
	input  logic                 pat_req_i,
	input  media_pkg::mem_addr_t pat_adr_i,
	input  bus_pkg::byte_t       pat_dat_i,
	input  logic                 wb_ack_i,
	output logic                 dec_done_o,
	output logic                 pat_done_o,
	output logic                 ioctl_wait_o,
	output logic                 wb_cyc_o,
	output logic                 wb_stb_o,
	output logic                 wb_we_o,
	output media_pkg::mem_addr_t wb_adr_o,
	output bus_pkg::byte_t       wb_dat_o,
	output bus_pkg::wb_sel_t     wb_sel_o
);

	// Set while the patcher owns the current cycle
	logic own_pat;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wb_cyc_o <= 1'b0;
			wb_stb_o <= 1'b0;
			own_pat <= 1'b0;
		end else if (wb_cyc_o) begin
			if (wb_ack_i) begin
				wb_cyc_o <= 1'b0;
				wb_stb_o <= 1'b0;
			end
		end else if (dec_req_i || pat_req_i) begin
			wb_cyc_o <= 1'b1;
			wb_stb_o <= 1'b1;
			// Decoder wins a tie
			own_pat <= !dec_req_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!wb_cyc_o) begin
			wb_adr_o <= dec_req_i ? dec_adr_i : pat_adr_i;
			wb_dat_o <= dec_req_i ? dec_dat_i : pat_dat_i;
		end
	end

	assign dec_done_o = wb_cyc_o && wb_ack_i && !own_pat;
	assign pat_done_o = wb_cyc_o && wb_ack_i && own_pat;
	// Host stalls for as long as a decoder write is outstanding
	assign ioctl_wait_o = dec_req_i;
	assign wb_we_o = wb_cyc_o;
	assign wb_sel_o = 1'b1;

	a_stb_cyc: assert property (@(posedge clk_sys) disable iff (reset)
		wb_stb_o |-> wb_cyc_o);
	a_adr_hold: assert property (@(posedge clk_sys) disable iff (reset)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o));

endmodule

// ==== logic/vic_loader_top.sv ====
////////////////////////////////////////
// Loader top level
////////////////////////////////////////

module vic_loader_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ioctl_download_i,
	input  bus_pkg::byte_t        ioctl_index_i,
	input  logic                  ioctl_wr_i,
	input  media_pkg::host_addr_t ioctl_addr_i,
	input  bus_pkg::byte_t        ioctl_dout_i,
	input  bus_pkg::byte_t        ioctl_ext_i,
	output logic                  ioctl_wait_o,
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic                  wb_we_o,
	output media_pkg::mem_addr_t  wb_adr_o,
	output bus_pkg::byte_t        wb_dat_o,
	output bus_pkg::wb_sel_t      wb_sel_o,
	input  logic                  wb_ack_i,
	input  logic                  opt_ram1_i,
	input  logic [1:0]            opt_ram2_i,
	input  logic                  opt_ram3_i,
	input  logic                  opt_cart_wr_i,
	output media_pkg::ram_ext_t   ram_ext_o,
	output media_pkg::ram_ext_t   ram_ext_ro_o
);

	logic                 dec_req;
	logic                 dec_done;
	logic                 pat_req;
	logic                 pat_done;
	logic                 cart_wr;
	logic                 prg_end;
	media_pkg::mem_addr_t dec_adr;
	media_pkg::mem_addr_t pat_adr;
	media_pkg::mem_addr_t end_adr;
	bus_pkg::byte_t       dec_dat;
	bus_pkg::byte_t       pat_dat;

	load_stream_decoder u_decoder (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download_i(ioctl_download_i), .ioctl_index_i(ioctl_index_i),
		.ioctl_wr_i(ioctl_wr_i), .ioctl_addr_i(ioctl_addr_i),
		.ioctl_dout_i(ioctl_dout_i), .ioctl_ext_i(ioctl_ext_i),
		.dec_done_i(dec_done), .dec_req_o(dec_req), .dec_adr_o(dec_adr),
		.dec_dat_o(dec_dat), .cart_wr_o(cart_wr), .prg_end_o(prg_end),
		.end_adr_o(end_adr)
	);

	basic_ptr_patcher u_patcher (
		.clk_sys(clk_sys), .reset(reset),
		.prg_end_i(prg_end), .end_adr_i(end_adr), .pat_done_i(pat_done),
		.pat_req_o(pat_req), .pat_adr_o(pat_adr), .pat_dat_o(pat_dat)
	);

	memory_config u_config (
		.clk_sys(clk_sys), .reset(reset),
		.cart_wr_i(cart_wr), .cart_adr_i(dec_adr),
		.opt_ram1_i(opt_ram1_i), .opt_ram2_i(opt_ram2_i), .opt_ram3_i(opt_ram3_i),
		.opt_cart_wr_i(opt_cart_wr_i),
		.ram_ext_o(ram_ext_o), .ram_ext_ro_o(ram_ext_ro_o)
	);

	wb_write_master u_master (
		.clk_sys(clk_sys), .reset(reset),
		.dec_req_i(dec_req), .dec_adr_i(dec_adr), .dec_dat_i(dec_dat),
		.pat_req_i(pat_req), .pat_adr_i(pat_adr), .pat_dat_i(pat_dat),
		.wb_ack_i(wb_ack_i), .dec_done_o(dec_done), .pat_done_o(pat_done),
		.ioctl_wait_o(ioctl_wait_o), .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o),
		.wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o),
		.wb_sel_o(wb_sel_o)
	);

endmodule

// ==== tb/wb_mem_model.sv ====
////////////////////////////////////////
// Wishbone slave memory, write only
////////////////////////////////////////

module wb_mem_model (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [15:0] wb_adr_i,
	input  logic [7:0]  wb_dat_i,
	input  logic [1:0]  delay_i,
	output logic        wb_ack_o
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] mem [0:65535];
	logic [1:0] wait_q;
	logic       busy_q;
	int         write_count;

	// Fill pattern built from both address bytes
	initial begin
		write_count = 0;
		for (int a = 0; a < 65536; a++)
			mem[a] = 8'(a >> 8) ^ {a[6:0], a[7]} ^ 8'hA5;
	end

	always @(posedge clk_sys) begin
		if (reset) begin
			wb_ack_o <= 1'b0;
			busy_q <= 1'b0;
			wait_q <= '0;
		end else if (wb_ack_o) begin
			wb_ack_o <= 1'b0;
			busy_q <= 1'b0;
		end else if (wb_cyc_i && wb_stb_i) begin
			if (!busy_q) begin
				busy_q <= 1'b1;
				wait_q <= delay_i;
			end else if (wait_q == 2'd0) begin
				wb_ack_o <= 1'b1;
				if (wb_we_i)
					mem[wb_adr_i] <= wb_dat_i;
				write_count <= write_count + 1;
			end else begin
				wait_q <= wait_q - 2'd1;
			end
		end
	end

endmodule

// ==== tb/tb_loader.sv ====
////////////////////////////////////////
// Loader testbench
// Drives host downloads, checks the memory image
////////////////////////////////////////

module tb_loader;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TOTAL_BYTES = 42 + 18 + 34 + 40 + 16;
	localparam int LIMIT_CYCLES = TOTAL_BYTES * 8 + 2000;

	logic clk_sys, reset;
	logic ioctl_download_i, ioctl_wr_i, ioctl_wait_o;
	logic [7:0] ioctl_index_i, ioctl_dout_i, ioctl_ext_i;
	logic [24:0] ioctl_addr_i;
	logic wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i;
	logic [15:0] wb_adr_o;
	logic [7:0] wb_dat_o;
	logic [0:0] wb_sel_o;
	logic opt_ram1_i, opt_ram3_i, opt_cart_wr_i;
	logic [1:0] opt_ram2_i;
	logic [4:0] ram_ext_o, ram_ext_ro_o;
	logic [31:0] rng, dly_rng;
	logic [7:0] exp_mem [0:65535];
	int chk_q[$];
	int errors, tests, base_count, exp_writes, err_start;

	vic_loader_top dut0 (.*);

	wb_mem_model mem0 (
		.clk_sys(clk_sys), .reset(reset), .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o),
		.wb_we_i(wb_we_o), .wb_adr_i(wb_adr_o), .wb_dat_i(wb_dat_o),
		.delay_i(dly_rng[17:16]), .wb_ack_o(wb_ack_i)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Ack delay of 0 to 3 cycles
	always @(posedge clk_sys)
		dly_rng <= lcg_next(dly_rng);

	//////////////////////////////////////// Protocol checks
	a_host_wait: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wait_o |-> !ioctl_wr_i)
		else begin
			$display("Host wrote a byte while ioctl_wait_o was high");
			errors++;
		end
	a_bus_hold: assert property (@(posedge clk_sys) disable iff (reset)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o))
		else begin
			$display("Bus cycle lost its address before ack");
			errors++;
		end
	a_bus_write: assert property (@(posedge clk_sys) disable iff (reset)
		wb_stb_o |-> wb_cyc_o && wb_we_o && wb_sel_o == 1'b1)
		else begin
			$display("Bus cycle is not a valid write");
			errors++;
		end

	//////////////////////////////////////// Host side
	task automatic send_byte(input int ofs, input logic [7:0] d);
		int guard;
		guard = 0;
		@(negedge clk_sys);
		while (ioctl_wait_o && guard < 100) begin
			@(negedge clk_sys);
			guard++;
		end
		if (guard >= 100) begin
			$display("Host stalled at offset %h, wait never fell", ofs);
			errors++;
		end
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b1;
		ioctl_addr_i <= 25'(ofs);
		ioctl_dout_i <= d;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
	endtask

	task automatic begin_download(input logic [7:0] idx, input logic [7:0] ext);
		base_count = mem0.write_count;
		exp_writes = 0;
		err_start = errors;
		@(posedge clk_sys);
		ioctl_index_i <= idx;
		ioctl_ext_i <= ext;
		ioctl_download_i <= 1'b1;
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		while (ioctl_wait_o)
			@(negedge clk_sys);
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
	endtask

	task automatic expect_write(input int a, input logic [7:0] d);
		exp_mem[a] = d;
		chk_q.push_back(a);
		exp_writes++;
	endtask

	// Linear load, optional two byte header, kept below limit
	task automatic load_linear(input logic [7:0] idx, input logic [7:0] ext, input bit hdr,
			input int start, input int n, input int limit, output int end_adr);
		logic [7:0] d;
		begin_download(idx, ext);
		if (hdr) begin
			send_byte(0, 8'(start));
			send_byte(1, 8'(start >> 8));
		end
		end_adr = start;
		for (int i = 0; i < n; i++) begin
			rng = lcg_next(rng);
			d = rng[23:16];
			if (start + i < limit) begin
				expect_write(start + i, d);
				end_adr = start + i + 1;
			end
			send_byte(hdr ? i + 2 : i, d);
		end
		end_download();
	endtask

	// Pointer cells take the end address low byte first
	task automatic expect_patch(input int end_adr);
		int cells[8] = '{'h2D, 'h2E, 'h2F, 'h30, 'h31, 'h32, 'hAE, 'hAF};
		for (int k = 0; k < 8; k++)
			expect_write(cells[k], (k % 2 == 0) ? 8'(end_adr) : 8'(end_adr >> 8));
	endtask

	task automatic finish_test(input string name);
		int guard;
		guard = 0;
		while (mem0.write_count < base_count + exp_writes && guard < 400) begin
			@(negedge clk_sys);
			guard++;
		end
		repeat (20) @(negedge clk_sys);
		assert (mem0.write_count == base_count + exp_writes)
			else begin
				$display("CHECK FAILED write_count: got %h expected %h",
					mem0.write_count - base_count, exp_writes);
				errors++;
			end
		foreach (chk_q[i])
			assert (mem0.mem[chk_q[i]] == exp_mem[chk_q[i]])
				else begin
					$display("CHECK FAILED mem[%h]: got %h expected %h", chk_q[i],
						mem0.mem[chk_q[i]], exp_mem[chk_q[i]]);
					errors++;
				end
		chk_q.delete();
		tests++;
		$display("%s: %s", name, (errors == err_start) ? "ok" : "FAILED");
	endtask

	task automatic check_cfg(input logic [4:0] ext, input logic [4:0] ro);
		@(negedge clk_sys);
		assert (ram_ext_o == ext)
			else begin
				$display("CHECK FAILED ram_ext_o: got %h expected %h", ram_ext_o, ext);
				errors++;
			end
		assert (ram_ext_ro_o == ro)
			else begin
				$display("CHECK FAILED ram_ext_ro_o: got %h expected %h", ram_ext_ro_o, ro);
				errors++;
			end
	endtask

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles", LIMIT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//////////////////////////////////////// Test sequence
	initial begin
		int end_adr;
		reset = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_wr_i = 1'b0;
		ioctl_index_i = '0;
		ioctl_dout_i = '0;
		ioctl_ext_i = '0;
		ioctl_addr_i = '0;
		opt_ram1_i = 1'b0;
		opt_ram2_i = 2'd2;
		opt_ram3_i = 1'b0;
		opt_cart_wr_i = 1'b0;
		rng = 32'h6fce5548;
		dly_rng = 32'h6fce5548;
		errors = 0;
		tests = 0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		for (int a = 0; a < 65536; a++)
			exp_mem[a] = mem0.mem[a];

		err_start = errors;
		check_cfg(5'b00110, 5'b00000);
		tests++;
		$display("ram option mask: %s", (errors == err_start) ? "ok" : "FAILED");

		load_linear(8'h01, 8'h00, 1'b1, 'h1001, 40, 'hA000, end_adr);
		expect_patch(end_adr);
		finish_test("prg load at 1001 with pointer patch");

		load_linear(8'h01, 8'h00, 1'b1, 'h9FF8, 16, 'hA000, end_adr);
		expect_patch(end_adr);
		finish_test("prg load clipped at a000");

		load_linear(8'h41, 8'h00, 1'b1, 'hA000, 32, 'hC000, end_adr);
		finish_test("crt load at a000");
		err_start = errors;
		check_cfg(5'b10110, 5'b10000);
		@(posedge clk_sys);
		opt_cart_wr_i <= 1'b1;
		repeat (2) @(posedge clk_sys);
		check_cfg(5'b10110, 5'b00000);
		tests++;
		$display("cartridge block masks: %s", (errors == err_start) ? "ok" : "FAILED");

		// Kernal image sampled around both window edges
		begin_download(8'h06, 8'h00);
		for (int ofs = 0; ofs < 'h8002; ofs++) begin
			if (ofs < 4 || (ofs >= 'h3FFE && ofs < 'h4010) || ofs >= 'h7FF0) begin
				rng = lcg_next(rng);
				if (ofs >= 'h4000 && ofs < 'h8000)
					expect_write(ofs + 'h8000, rng[23:16]);
				send_byte(ofs, rng[23:16]);
			end
		end
		end_download();
		finish_test("rom window moved to c000");

		load_linear(8'h81, "6", 1'b0, 'h6000, 16, 'hC000, end_adr);
		finish_test("ct load from extension 6");

		if (errors == 0) begin
			$display("%0d tests run, 0 failed checks", tests);
			$display("Simulation finished: PASS");
		end else begin
			$display("%0d tests run, %0d failed checks", tests, errors);
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
logic/media_pkg.sv
logic/bus_pkg.sv
logic/load_stream_decoder.sv
logic/basic_ptr_patcher.sv
logic/memory_config.sv
logic/wb_write_master.sv
logic/vic_loader_top.sv
tb/wb_mem_model.sv
tb/tb_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the loader testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_loader --Mdir obj_dir -o tb_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_loader > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
exit 1
